// File: bench/tbBuzzerSoc.sv
`timescale 1ns/1ps

module tbBuzzerSoc;

    localparam int          READY_TIMEOUT = 20;
    localparam int          PWM_TIMEOUT   = 400;
    localparam int          RAM_WORDS     = 32;
    localparam logic [31:0] REG_BASE      = 32'h1 << socPkg::REG_REGION_BIT;

    logic             clk = 1'b0;
    logic             RSTn;
    socPkg::ahbReq_t  bus;
    socPkg::ahbResp_t busResp;
    logic             pwm;

    int          errors    = 0;
    int          checks    = 0;
    int          edgeCount = 0;
    logic        pwmSeen   = 1'b0;
    int          ramBase;
    logic [31:0] ramModel [RAM_WORDS];

    BuzzerSoc dut0 (.*);

    always #5 clk = ~clk;

    // Rising edges of pwm, sampled between clock edges
    always @(negedge clk) begin
        if (pwm && !pwmSeen) begin
            edgeCount++;
        end
        pwmSeen = pwm;
    end

    function automatic logic [31:0] regAddr(input int offset);
        return REG_BASE | 32'(offset);
    endfunction

    function automatic logic [31:0] voiceAddr(input int voice, input int field);
        return regAddr(buzzerPkg::REG_VOICE_BASE + voice * buzzerPkg::REG_VOICE_STRIDE + field);
    endfunction

    function automatic logic [31:0] ramAddr(input int word);
        return 32'(ramBase + word) << 2;
    endfunction

    function automatic logic [31:0] voiceCtrl(input int voice, input logic invert);
        return (32'h1 << buzzerPkg::CTRL_ENABLE) | (32'(invert) << buzzerPkg::CTRL_INVERT)
               | (32'h1 << (buzzerPkg::CTRL_VOICE_EN + voice));
    endfunction

    // Expected word after a write, from the RAM byte lanes or the register map
    function automatic logic [31:0] expectWord(input logic [31:0] addr,
                                               input socPkg::ahbSize_t size,
                                               input logic [31:0] oldWord,
                                               input logic [31:0] data);
        logic [31:0] result;
        logic [31:0] ctrlMask;
        int          offset;
        int          first;
        result   = oldWord;
        offset   = int'(addr[7:0]);
        first    = int'(addr[1:0]);
        ctrlMask = (32'h1 << buzzerPkg::CTRL_ENABLE) | (32'h1 << buzzerPkg::CTRL_INVERT)
                   | (((32'h1 << buzzerPkg::NUM_VOICES) - 1) << buzzerPkg::CTRL_VOICE_EN);
        if (addr[socPkg::REG_REGION_BIT]) begin
            if (offset == buzzerPkg::REG_CTRL) begin
                result = data & ctrlMask;
            end else if (offset >= buzzerPkg::REG_VOICE_BASE) begin
                // Period and duty keep 16 bits
                result = {16'h0, data[15:0]};
            end else begin
                result = '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (b >= first && b < first + (1 << size)) begin
                    result[8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        return result;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic abortRun();
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // ----------------------------------------
    // Bus transfers
    // ----------------------------------------
    task automatic driveAddr(input logic [31:0] addr, input logic write,
                             input socPkg::ahbSize_t size);
        bus.sel   = 1'b1;
        bus.addr  = addr;
        bus.trans = socPkg::TRANS_NONSEQ;
        bus.write = write;
        bus.size  = size;
    endtask

    task automatic driveIdle();
        bus.sel   = 1'b0;
        bus.trans = socPkg::TRANS_IDLE;
    endtask

    // Ready is registered, so the value at the falling edge holds at the next rising edge
    task automatic waitReady(input string what);
        int cycles;
        cycles = 0;
        while (!busResp.readyOut && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!busResp.readyOut) begin
            $display("Timeout: no ready in the %s phase after %0d cycles", what, cycles);
            abortRun();
        end
    endtask

    task automatic busWrite(input logic [31:0] addr, input socPkg::ahbSize_t size,
                            input logic [31:0] data);
        driveAddr(addr, 1'b1, size);
        waitReady("write address");
        @(negedge clk);
        driveIdle();
        bus.wdata = data;
        waitReady("write data");
        @(negedge clk);
    endtask

    task automatic busRead(input logic [31:0] addr, output logic [31:0] data);
        driveAddr(addr, 1'b0, socPkg::SIZE_WORD);
        waitReady("read address");
        @(negedge clk);
        driveIdle();
        waitReady("read data");
        data = busResp.rdata;
        @(negedge clk);
    endtask

    // Read address phase overlaps the write data phase
    task automatic writeThenRead(input logic [31:0] addr, input socPkg::ahbSize_t size,
                                 input logic [31:0] data, output logic [31:0] rd);
        driveAddr(addr, 1'b1, size);
        waitReady("write address");
        @(negedge clk);
        bus.wdata = data;
        driveAddr({addr[31:2], 2'b00}, 1'b0, socPkg::SIZE_WORD);
        waitReady("write data");
        @(negedge clk);
        driveIdle();
        // Idle address moves on, so a stalled read has to replay its own word
        bus.addr = addr ^ 32'h4;
        waitReady("read data");
        rd = busResp.rdata;
        @(negedge clk);
    endtask

    task automatic waitPwm(input logic value);
        int cycles;
        cycles = 0;
        while (pwm !== value && cycles < PWM_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (pwm !== value) begin
            $display("Timeout: pwm did not go to %b within %0d cycles", value, cycles);
            abortRun();
        end
    endtask

    // One full pulse, starting at a rising edge
    task automatic measurePwm(output int highTime, output int periodTime);
        int lowTime;
        waitPwm(1'b0);
        waitPwm(1'b1);
        highTime = 0;
        lowTime  = 0;
        while (pwm && highTime < PWM_TIMEOUT) begin
            highTime++;
            @(negedge clk);
        end
        while (!pwm && lowTime < PWM_TIMEOUT) begin
            lowTime++;
            @(negedge clk);
        end
        periodTime = highTime + lowTime;
    endtask

    task automatic checkRegsZero(input string when);
        logic [31:0] rd;
        busRead(regAddr(buzzerPkg::REG_CTRL), rd);
        checkValue($sformatf("%s, CTRL", when), rd, 32'h0);
        busRead(regAddr(buzzerPkg::REG_PULSES), rd);
        checkValue($sformatf("%s, PULSES", when), rd, 32'h0);
        for (int v = 0; v < buzzerPkg::NUM_VOICES; v++) begin
            busRead(voiceAddr(v, buzzerPkg::REG_PERIOD), rd);
            checkValue($sformatf("%s, voice %0d period", when, v), rd, 32'h0);
            busRead(voiceAddr(v, buzzerPkg::REG_DUTY), rd);
            checkValue($sformatf("%s, voice %0d duty", when, v), rd, 32'h0);
        end
    endtask

    task automatic checkRam(input string when);
        logic [31:0] rd;
        for (int w = 0; w < RAM_WORDS; w++) begin
            busRead(ramAddr(w), rd);
            checkValue($sformatf("%s, RAM word %0d", when, w), rd, ramModel[w]);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      rd;
        logic [31:0]      periodModel [buzzerPkg::NUM_VOICES];
        logic [31:0]      dutyModel [buzzerPkg::NUM_VOICES];
        socPkg::ahbSize_t size;
        int               word;
        int               voice;
        int               period;
        int               duty;
        int               highTime;
        int               periodTime;
        int               cycles;
        RSTn = 1'b0;
        bus  = '0;
        void'($urandom(32'h32048acc));
        repeat (3) @(negedge clk);
        RSTn = 1'b1;
        @(negedge clk);
        checkValue("pwm after reset", pwm, 1'b0);
        checkValue("readyOut after reset", busResp.readyOut, 1'b1);
        checkRegsZero("After reset");

        // Word fill, then random byte, halfword and word writes
        ramBase = $urandom % (2**socPkg::RAM_ADDR_BITS - RAM_WORDS);
        for (int w = 0; w < RAM_WORDS; w++) begin
            ramModel[w] = $urandom;
            busWrite(ramAddr(w), socPkg::SIZE_WORD, ramModel[w]);
        end
        for (int i = 0; i < 72; i++) begin
            word = $urandom % RAM_WORDS;
            size = socPkg::ahbSize_t'($urandom % 3);
            addr = ramAddr(word) | (32'($urandom % 4) & ~((32'h1 << size) - 1));
            data = $urandom;
            ramModel[word] = expectWord(addr, size, ramModel[word], data);
            if (i < 56) begin
                busWrite(addr, size, data);
            end else begin
                writeThenRead(addr, size, data, rd);
                checkValue($sformatf("Read after write, word %0d", word), rd, ramModel[word]);
            end
        end
        checkRam("Read-back");

        // Register readback
        for (int v = 0; v < buzzerPkg::NUM_VOICES; v++) begin
            data = $urandom;
            periodModel[v] = expectWord(voiceAddr(v, buzzerPkg::REG_PERIOD), 2, '0, data);
            busWrite(voiceAddr(v, buzzerPkg::REG_PERIOD), socPkg::SIZE_WORD, data);
            data = $urandom;
            dutyModel[v] = expectWord(voiceAddr(v, buzzerPkg::REG_DUTY), 2, '0, data);
            busWrite(voiceAddr(v, buzzerPkg::REG_DUTY), socPkg::SIZE_WORD, data);
        end
        data = $urandom & ~(32'h1 << buzzerPkg::CTRL_SOFT_RESET);
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, data);
        busRead(regAddr(buzzerPkg::REG_CTRL), rd);
        checkValue("CTRL", rd, expectWord(regAddr(buzzerPkg::REG_CTRL), 2, '0, data));
        for (int v = 0; v < buzzerPkg::NUM_VOICES; v++) begin
            busRead(voiceAddr(v, buzzerPkg::REG_PERIOD), rd);
            checkValue($sformatf("Voice %0d period", v), rd, periodModel[v]);
            busRead(voiceAddr(v, buzzerPkg::REG_DUTY), rd);
            checkValue($sformatf("Voice %0d duty", v), rd, dutyModel[v]);
        end

        // Single voice, normal then inverted
        voice  = $urandom % buzzerPkg::NUM_VOICES;
        period = 8 + $urandom % 24;
        duty   = 1 + $urandom % (period - 1);
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, 32'h0);
        busWrite(voiceAddr(voice, buzzerPkg::REG_PERIOD), socPkg::SIZE_WORD, period);
        busWrite(voiceAddr(voice, buzzerPkg::REG_DUTY), socPkg::SIZE_WORD, duty);
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, voiceCtrl(voice, 1'b0));
        measurePwm(highTime, periodTime);
        checkValue("pwm high time", highTime, duty);
        checkValue("pwm period", periodTime, period);
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, 32'h0);
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, voiceCtrl(voice, 1'b1));
        measurePwm(highTime, periodTime);
        checkValue("Inverted pwm high time", highTime, period - duty);
        checkValue("Inverted pwm period", periodTime, period);

        // Pulse counter against the edges seen here
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, 32'h0);
        busWrite(regAddr(buzzerPkg::REG_PULSES), socPkg::SIZE_WORD, 32'h0);
        edgeCount = 0;
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, voiceCtrl(voice, 1'b0));
        cycles = 0;
        while (edgeCount < 6 && cycles < PWM_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (edgeCount < 6) begin
            $display("Timeout: only %0d pwm pulses in %0d cycles", edgeCount, cycles);
            abortRun();
        end
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, 32'h0);
        busRead(regAddr(buzzerPkg::REG_PULSES), rd);
        checkValue("Pulse count", rd, edgeCount);

        // Soft reset while the voice is sounding
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, voiceCtrl(voice, 1'b0));
        waitPwm(1'b1);
        data = voiceCtrl(voice, 1'b0) | (32'h1 << buzzerPkg::CTRL_SOFT_RESET);
        busWrite(regAddr(buzzerPkg::REG_CTRL), socPkg::SIZE_WORD, data);
        // A voice still running would drive pwm high within one period
        highTime = 0;
        for (int i = 0; i < period; i++) begin
            if (pwm) begin
                highTime++;
            end
            @(negedge clk);
        end
        checkValue("pwm high cycles after soft reset", highTime, 0);
        checkRegsZero("After soft reset");
        checkRam("After soft reset");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tbBuzzerSoc -o simBuzzerSoc \
    && ./obj_dir/simBuzzerSoc > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^TEST RESULT: PASS$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: source/BuzzerSoc.sv
`timescale 1ns/1ps

module BuzzerSoc (
    input  logic             clk,
    input  logic             RSTn,
    input  socPkg::ahbReq_t  bus,
    output socPkg::ahbResp_t busResp,
    output logic             pwm
);

    socPkg::ahbReq_t                                  ramReq;
    socPkg::ahbReq_t                                  regReq;
    socPkg::ahbResp_t                                 ramResp;
    socPkg::ahbResp_t                                 regResp;
    socPkg::ramAddr_t                                 wrAddr;
    socPkg::ramAddr_t                                 rdAddr;
    socPkg::ahbData_t                                 wrData;
    socPkg::ahbData_t                                 rdData;
    socPkg::byteEn_t                                  wrEn;
    buzzerPkg::voiceCfg_t [buzzerPkg::NUM_VOICES-1:0] voiceCfg;
    logic [buzzerPkg::NUM_VOICES-1:0]                 levels;
    logic                                             mixEnable;
    logic                                             mixInvert;
    logic                                             clearPulses;
    buzzerPkg::pulseCount_t                           pulseCount;
    logic                                             sysRstn;

    // ----------------------------------------
    // Bus and memory
    // ----------------------------------------
    ahbDecoder decoder0 (
        .clk     (clk),
        .RSTn    (sysRstn),
        .bus     (bus),
        .busResp (busResp),
        .ramReq  (ramReq),
        .regReq  (regReq),
        .ramResp (ramResp),
        .regResp (regResp)
    );

    ahbRam ramIf0 (
        .clk    (clk),
        .RSTn   (sysRstn),
        .req    (ramReq),
        .resp   (ramResp),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wrEn   (wrEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    blockRam ram0 (
        .clk    (clk),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wrEn   (wrEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    // ----------------------------------------
    // Buzzer
    // ----------------------------------------
    // Takes the pin reset and hands out the system reset
    buzzerRegs regs0 (
        .clk         (clk),
        .RSTn        (RSTn),
        .req         (regReq),
        .resp        (regResp),
        .voiceCfg    (voiceCfg),
        .mixEnable   (mixEnable),
        .mixInvert   (mixInvert),
        .clearPulses (clearPulses),
        .pulseCount  (pulseCount),
        .sysRstn     (sysRstn)
    );

    for (genvar v = 0; v < buzzerPkg::NUM_VOICES; v++) begin : genVoice
        toneVoice voice (
            .clk   (clk),
            .RSTn  (sysRstn),
            .cfg   (voiceCfg[v]),
            .level (levels[v])
        );
    end

    pwmMixer mixer0 (
        .clk         (clk),
        .RSTn        (sysRstn),
        .levels      (levels),
        .enable      (mixEnable),
        .invert      (mixInvert),
        .clearPulses (clearPulses),
        .pwm         (pwm),
        .pulseCount  (pulseCount)
    );

endmodule

// File: source/ahbDecoder.sv
`timescale 1ns/1ps

module ahbDecoder (
    input  logic             clk,
    input  logic             RSTn,
    input  socPkg::ahbReq_t  bus,
    output socPkg::ahbResp_t busResp,
    output socPkg::ahbReq_t  ramReq,
    output socPkg::ahbReq_t  regReq,
    input  socPkg::ahbResp_t ramResp,
    input  socPkg::ahbResp_t regResp
);

    logic regRegion;
    logic ready;
    logic dataRam;
    logic dataReg;

    assign regRegion = bus.addr[socPkg::REG_REGION_BIT];

    // Global HREADY is the muxed response
    assign ready = busResp.readyOut;

    // ----------------------------------------
    // Address phase fan-out
    // ----------------------------------------
    always_comb begin
        ramReq       = bus;
        ramReq.sel   = bus.sel && !regRegion;
        ramReq.ready = ready;
        regReq       = bus;
        regReq.sel   = bus.sel && regRegion;
        regReq.ready = ready;
    end

    // Target of the current data phase, held over a stall
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            dataRam <= 1'b0;
            dataReg <= 1'b0;
        end else if (ready) begin
            dataRam <= ramReq.sel && bus.trans == socPkg::TRANS_NONSEQ;
            dataReg <= regReq.sel && bus.trans == socPkg::TRANS_NONSEQ;
        end
    end

    // ----------------------------------------
    // Response mux
    // ----------------------------------------
    always_comb begin
        if (dataRam) begin
            busResp = ramResp;
        end else if (dataReg) begin
            busResp = regResp;
        end else begin
            // No transfer in flight, bus is free
            busResp.rdata    = '0;
            busResp.readyOut = 1'b1;
        end
    end

    // Only the target of the current data phase may stall the bus
    assert property (@(posedge clk) disable iff (!RSTn)
        (dataRam || ramResp.readyOut) && (dataReg || regResp.readyOut));

endmodule

// File: source/ahbRam.sv
`timescale 1ns/1ps

module ahbRam (
    input  logic             clk,
    input  logic             RSTn,
    input  socPkg::ahbReq_t  req,
    output socPkg::ahbResp_t resp,
    output socPkg::ramAddr_t wrAddr,
    output socPkg::ahbData_t wrData,
    output socPkg::byteEn_t  wrEn,
    output socPkg::ramAddr_t rdAddr,
    input  socPkg::ahbData_t rdData
);

    socPkg::ramPhase_t phase;
    socPkg::ramAddr_t  reqWord;
    socPkg::ramAddr_t  rdAddrQ;
    socPkg::byteEn_t   byteEnQ;
    logic              accept;
    logic              hazard;

    // Byte lanes from transfer size and the low address bits
    function automatic socPkg::byteEn_t laneMask(socPkg::ahbSize_t size, logic [1:0] offset);
        case (size)
            socPkg::SIZE_BYTE: return socPkg::byteEn_t'(1) << offset;
            socPkg::SIZE_HALF: return offset[1] ? 4'b1100 : 4'b0011;
            socPkg::SIZE_WORD: return 4'b1111;
            default:           return 4'b0000;
        endcase
    endfunction

    assign accept  = req.sel && req.trans == socPkg::TRANS_NONSEQ && req.ready;
    assign reqWord = req.addr[socPkg::RAM_ADDR_BITS+1:2];

    // ----------------------------------------
    // Phase machine
    // ----------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            phase  <= socPkg::ramIdle;
            hazard <= 1'b0;
        end else begin
            // Read of the word being written this cycle would see old data
            hazard <= accept && !req.write && phase == socPkg::ramWritePending
                      && reqWord == wrAddr;
            if (req.ready) begin
                phase <= (accept && req.write) ? socPkg::ramWritePending : socPkg::ramIdle;
            end
        end
    end

    // Address phase capture
    always_ff @(posedge clk) begin
        if (accept) begin
            rdAddrQ <= reqWord;
            if (req.write) begin
                wrAddr  <= reqWord;
                byteEnQ <= laneMask(req.size, req.addr[1:0]);
            end
        end
    end

    // Write data arrives in the data phase, already on its lanes
    assign wrEn   = (phase == socPkg::ramWritePending) ? byteEnQ : '0;
    assign wrData = req.wdata;

    // Replay the stalled read once the write has landed
    assign rdAddr        = hazard ? rdAddrQ : reqWord;
    assign resp.rdata    = rdData;
    assign resp.readyOut = !hazard;

    // Each write strobe belongs to a write address phase one cycle earlier
    assert property (@(posedge clk) disable iff (!RSTn)
        (wrEn != '0) |-> (phase == socPkg::ramWritePending) && $past(accept && req.write));

endmodule

// File: source/blockRam.sv
`timescale 1ns/1ps

module blockRam (
    input  logic             clk,
    input  socPkg::ramAddr_t wrAddr,
    input  socPkg::ahbData_t wrData,
    input  socPkg::byteEn_t  wrEn,
    input  socPkg::ramAddr_t rdAddr,
    output socPkg::ahbData_t rdData
);

    socPkg::ahbData_t mem [2**socPkg::RAM_ADDR_BITS];

    // Byte-wide write port
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < $bits(socPkg::byteEn_t); lane++) begin
            if (wrEn[lane]) begin
                mem[wrAddr][8*lane +: 8] <= wrData[8*lane +: 8];
            end
        end
    end

    // Registered read, old data on a same-word collision
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: source/buzzerPkg.sv
package buzzerPkg;

    localparam int NUM_VOICES = 4;

    typedef logic [15:0] toneCount_t;
    typedef logic [15:0] pulseCount_t;
    typedef logic [7:0]  regOffset_t;

    // Per-voice setup from the register block
    typedef struct packed {
        logic       enable;
        toneCount_t period;
        toneCount_t duty;
    } voiceCfg_t;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam regOffset_t REG_CTRL       = 8'h00;
    localparam regOffset_t REG_PULSES     = 8'h04;
    localparam regOffset_t REG_VOICE_BASE = 8'h10;

    localparam int REG_VOICE_STRIDE = 8;
    localparam int REG_PERIOD       = 0;
    localparam int REG_DUTY         = 4;

    // CTRL bit positions, voice enables start at CTRL_VOICE_EN
    localparam int CTRL_ENABLE     = 0;
    localparam int CTRL_INVERT     = 1;
    localparam int CTRL_SOFT_RESET = 2;
    localparam int CTRL_VOICE_EN   = 8;

endpackage

// File: source/buzzerRegs.sv
`timescale 1ns/1ps

module buzzerRegs (
    input  logic                                             clk,
    input  logic                                             RSTn,
    input  socPkg::ahbReq_t                                  req,
    output socPkg::ahbResp_t                                 resp,
    output buzzerPkg::voiceCfg_t [buzzerPkg::NUM_VOICES-1:0] voiceCfg,
    output logic                                             mixEnable,
    output logic                                             mixInvert,
    output logic                                             clearPulses,
    input  buzzerPkg::pulseCount_t                           pulseCount,
    output logic                                             sysRstn
);

    logic                              accept;
    logic                              dataActive;
    logic                              dataWrite;
    buzzerPkg::regOffset_t             dataOffset;
    logic                              regWrite;
    logic                              softReset;
    logic [buzzerPkg::NUM_VOICES-1:0]  voiceEn;
    buzzerPkg::toneCount_t             period [buzzerPkg::NUM_VOICES];
    buzzerPkg::toneCount_t             duty [buzzerPkg::NUM_VOICES];
    socPkg::ahbData_t                  readData;

    function automatic buzzerPkg::regOffset_t voiceOffset(int voice, int field);
        return buzzerPkg::regOffset_t'(buzzerPkg::REG_VOICE_BASE
                                       + voice * buzzerPkg::REG_VOICE_STRIDE + field);
    endfunction

    assign accept      = req.sel && req.trans == socPkg::TRANS_NONSEQ && req.ready;
    assign regWrite    = dataActive && dataWrite;
    assign softReset   = regWrite && dataOffset == buzzerPkg::REG_CTRL
                         && req.wdata[buzzerPkg::CTRL_SOFT_RESET];
    assign clearPulses = regWrite && dataOffset == buzzerPkg::REG_PULSES;

    // ----------------------------------------
    // System reset
    // ----------------------------------------
    // Low for one cycle after a soft reset write
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            sysRstn <= 1'b0;
        end else begin
            sysRstn <= !softReset;
        end
    end

    // Data phase tracking
    always_ff @(posedge clk or negedge sysRstn) begin
        if (!sysRstn) begin
            dataActive <= 1'b0;
        end else if (req.ready) begin
            dataActive <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dataWrite  <= req.write;
            dataOffset <= buzzerPkg::regOffset_t'(req.addr);
        end
    end

    // ----------------------------------------
    // Control and voice registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge sysRstn) begin
        if (!sysRstn) begin
            mixEnable <= 1'b0;
            mixInvert <= 1'b0;
            voiceEn   <= '0;
            for (int v = 0; v < buzzerPkg::NUM_VOICES; v++) begin
                period[v] <= '0;
                duty[v]   <= '0;
            end
        end else if (regWrite) begin
            if (dataOffset == buzzerPkg::REG_CTRL) begin
                mixEnable <= req.wdata[buzzerPkg::CTRL_ENABLE];
                mixInvert <= req.wdata[buzzerPkg::CTRL_INVERT];
                voiceEn   <= req.wdata[buzzerPkg::CTRL_VOICE_EN +: buzzerPkg::NUM_VOICES];
            end
            for (int v = 0; v < buzzerPkg::NUM_VOICES; v++) begin
                if (dataOffset == voiceOffset(v, buzzerPkg::REG_PERIOD)) begin
                    period[v] <= buzzerPkg::toneCount_t'(req.wdata);
                end
                if (dataOffset == voiceOffset(v, buzzerPkg::REG_DUTY)) begin
                    duty[v] <= buzzerPkg::toneCount_t'(req.wdata);
                end
            end
        end
    end

    // Readback, soft reset bit always reads 0
    always_comb begin
        readData = '0;
        if (dataOffset == buzzerPkg::REG_CTRL) begin
            readData[buzzerPkg::CTRL_ENABLE] = mixEnable;
            readData[buzzerPkg::CTRL_INVERT] = mixInvert;
            readData[buzzerPkg::CTRL_VOICE_EN +: buzzerPkg::NUM_VOICES] = voiceEn;
        end
        if (dataOffset == buzzerPkg::REG_PULSES) begin
            readData = socPkg::ahbData_t'(pulseCount);
        end
        for (int v = 0; v < buzzerPkg::NUM_VOICES; v++) begin
            if (dataOffset == voiceOffset(v, buzzerPkg::REG_PERIOD)) begin
                readData = socPkg::ahbData_t'(period[v]);
            end
            if (dataOffset == voiceOffset(v, buzzerPkg::REG_DUTY)) begin
                readData = socPkg::ahbData_t'(duty[v]);
            end
        end
    end

    assign resp.rdata    = readData;
    assign resp.readyOut = 1'b1;

    always_comb begin
        for (int v = 0; v < buzzerPkg::NUM_VOICES; v++) begin
            voiceCfg[v].enable = voiceEn[v];
            voiceCfg[v].period = period[v];
            voiceCfg[v].duty   = duty[v];
        end
    end

endmodule

// File: source/pwmMixer.sv
`timescale 1ns/1ps

module pwmMixer (
    input  logic                             clk,
    input  logic                             RSTn,
    input  logic [buzzerPkg::NUM_VOICES-1:0] levels,
    input  logic                             enable,
    input  logic                             invert,
    input  logic                             clearPulses,
    output logic                             pwm,
    output buzzerPkg::pulseCount_t           pulseCount
);

    logic pwmPrev;
    logic rise;

    // Disabled output stays low whatever the polarity
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            pwm     <= 1'b0;
            pwmPrev <= 1'b0;
        end else begin
            pwm     <= enable && ((|levels) ^ invert);
            pwmPrev <= pwm;
        end
    end

    assign rise = pwm && !pwmPrev;

    // ----------------------------------------
    // Pulse counter, saturating
    // ----------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            pulseCount <= '0;
        end else if (clearPulses) begin
            pulseCount <= '0;
        end else if (rise && pulseCount != '1) begin
            pulseCount <= pulseCount + 1'b1;
        end
    end

endmodule

// File: source/socPkg.sv
package socPkg;

    // ----------------------------------------
    // AHB-lite bus types
    // ----------------------------------------
    typedef logic [31:0] ahbAddr_t;
    typedef logic [31:0] ahbData_t;
    typedef logic [1:0]  ahbTrans_t;
    typedef logic [2:0]  ahbSize_t;

    localparam ahbTrans_t TRANS_IDLE   = 2'b00;
    localparam ahbTrans_t TRANS_NONSEQ = 2'b10;

    localparam ahbSize_t SIZE_BYTE = 3'd0;
    localparam ahbSize_t SIZE_HALF = 3'd1;
    localparam ahbSize_t SIZE_WORD = 3'd2;

    // Master to slave, ready is the global HREADY
    typedef struct packed {
        logic      sel;
        ahbAddr_t  addr;
        ahbTrans_t trans;
        logic      write;
        ahbSize_t  size;
        ahbData_t  wdata;
        logic      ready;
    } ahbReq_t;

    typedef struct packed {
        ahbData_t rdata;
        logic     readyOut;
    } ahbResp_t;

    // ----------------------------------------
    // Memory map and RAM
    // ----------------------------------------
    // Set selects the buzzer registers, clear the RAM
    localparam int REG_REGION_BIT = 30;

    // Word address bits, 4 KB
    localparam int RAM_ADDR_BITS = 10;

    typedef logic [RAM_ADDR_BITS-1:0] ramAddr_t;
    typedef logic [3:0]               byteEn_t;

    typedef enum logic {
        ramIdle,
        ramWritePending
    } ramPhase_t;

endpackage

// File: source/toneVoice.sv
`timescale 1ns/1ps

module toneVoice (
    input  logic                 clk,
    input  logic                 RSTn,
    input  buzzerPkg::voiceCfg_t cfg,
    output logic                 level
);

    buzzerPkg::toneCount_t count;

    // Period counter, 0 to period-1
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            count <= '0;
        end else if (!cfg.enable) begin
            count <= '0;
        end else if (count >= cfg.period - 1'b1) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // High for the first duty counts of each period
    assign level = cfg.enable && count < cfg.duty;

    // Counter stays inside the period once the period has settled
    assert property (@(posedge clk) disable iff (!RSTn)
        cfg.enable && cfg.period != '0 && $stable(cfg.period) |-> count < cfg.period);

endmodule

// File: sources.f
source/socPkg.sv
source/buzzerPkg.sv
source/blockRam.sv
source/ahbRam.sv
source/ahbDecoder.sv
source/toneVoice.sv
source/pwmMixer.sv
source/buzzerRegs.sv
source/BuzzerSoc.sv
bench/tbBuzzerSoc.sv
